//--- design/rv_alu_pkg.sv
package rv_alu_pkg;

    // ======================================================================
    // widths and register map
    // ======================================================================
    localparam int XLEN   = 32;       // data width
    localparam int NREGS  = 32;       // x0..x31
    localparam int ADR_W  = 10;       // wishbone byte address width

    localparam logic [ADR_W-1:0] ADR_STATUS   = 10'h000; // instr write / status read
    localparam logic [ADR_W-1:0] ADR_REG_BASE = 10'h080; // x0 here, x31 at 0x0fc

    typedef logic [4:0] reg_idx_t;

    // ======================================================================
    // opcodes and alu operations
    // ======================================================================
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10         // lui
    } alu_op_e;

    // ======================================================================
    // instruction formats
    // ======================================================================
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // same word, two views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

//--- design/dec_exe_if.sv
`timescale 1ns/1ps

interface dec_exe_if import rv_alu_pkg::*; ();

    logic            valid;
    alu_op_e         op;
    reg_idx_t        rs1;
    reg_idx_t        rs2;
    reg_idx_t        rd;
    logic [XLEN-1:0] imm;
    logic            use_imm;     // operand b from imm
    logic            wen;         // writes rd
    logic            illegal;

    modport dec (
        output valid, op, rs1, rs2, rd, imm, use_imm, wen, illegal
    );

    modport exe (
        input valid, op, rs1, rs2, rd, imm, use_imm, wen, illegal
    );

endinterface

//--- design/exe_res_if.sv
`timescale 1ns/1ps

interface exe_res_if import rv_alu_pkg::*; ();

    // pending write, one cycle before it lands in the register file
    logic            valid;
    reg_idx_t        rd;
    logic            wen;
    logic            illegal;
    logic [XLEN-1:0] data;

    // operand read ports
    reg_idx_t        rs1_idx;
    reg_idx_t        rs2_idx;
    logic [XLEN-1:0] rs1_data;    // already bypassed
    logic [XLEN-1:0] rs2_data;

    modport exe (
        output valid, rd, wen, illegal, data, rs1_idx, rs2_idx,
        input  rs1_data, rs2_data
    );

    modport res (
        input  valid, rd, wen, illegal, data, rs1_idx, rs2_idx,
        output rs1_data, rs2_data
    );

endinterface

//--- design/rv_bus_port.sv
`timescale 1ns/1ps

module rv_bus_port import rv_alu_pkg::*; #(
    parameter int CNT_W = 16
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    // wishbone classic slave
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  logic [ADR_W-1:0] wb_adr_i,
    input  logic [XLEN-1:0]  wb_dat_i,
    input  logic [3:0]       wb_sel_i,
    output logic [XLEN-1:0]  wb_dat_o,
    output logic             wb_ack_o,
    // to decode
    output logic [XLEN-1:0]  instr_o,
    output logic             instr_valid_o,
    // from result
    output reg_idx_t         reg_idx_o,
    input  logic [XLEN-1:0]  reg_data_i,
    input  logic [CNT_W-1:0] retired_i,
    input  logic [CNT_W-1:0] illegal_i
);

    localparam logic [1:0] RD_WAIT = 2'd1; // ack lands on the third edge

    logic            new_req;
    logic            rd_busy;
    logic [1:0]      rd_cnt;
    logic            hit_status;
    logic            hit_reg;
    logic [XLEN-1:0] status_word;
    logic [XLEN-1:0] rd_data;

    // fresh request only, not one already being served
    assign new_req = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~rd_busy;

    assign hit_status = (wb_adr_i == ADR_STATUS);
    assign hit_reg    = (wb_adr_i[ADR_W-1:7] == ADR_REG_BASE[ADR_W-1:7]) &&
                        (wb_adr_i[1:0] == 2'b00);
    assign reg_idx_o  = wb_adr_i[6:2];

    assign instr_o       = wb_dat_i;
    assign instr_valid_o = new_req & wb_we_i & hit_status & (&wb_sel_i);

    assign status_word = (XLEN'(retired_i) << 16) | XLEN'(illegal_i);

    always_comb begin
        if (hit_status) rd_data = status_word;
        else if (hit_reg) rd_data = reg_data_i;
        else rd_data = '0;             // unmapped
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o <= 1'b0;
            rd_busy  <= 1'b0;
            rd_cnt   <= '0;
        end else begin
            wb_ack_o <= 1'b0;              // single cycle ack
            if (new_req && wb_we_i) begin
                wb_ack_o <= 1'b1;
            end else if (new_req) begin
                rd_busy <= 1'b1;
                rd_cnt  <= RD_WAIT;
            end else if (rd_busy) begin
                if (rd_cnt == 2'd0) begin
                    wb_ack_o <= 1'b1;
                    rd_busy  <= 1'b0;
                end else begin
                    rd_cnt <= rd_cnt - 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_busy && rd_cnt == 2'd0) wb_dat_o <= rd_data; // sampled with the ack
    end

endmodule

//--- design/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_alu_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic [XLEN-1:0] instr_i,
    input  logic            instr_valid_i,
    dec_exe_if.dec          dec_o
);

    instr_u          instr;
    opcode_e         opcode;
    alu_op_e         op;
    logic [XLEN-1:0] imm;
    logic            use_imm;
    logic            wen;
    logic            illegal;
    logic            f7_zero;
    logic            f7_alt;

    assign instr   = instr_i;
    assign opcode  = opcode_e'(instr.r.opcode);
    assign f7_zero = (instr.r.funct7 == 7'b0000000);
    assign f7_alt  = (instr.r.funct7 == 7'b0100000); // sub / sra

    // ======================================================================
    // field decode
    // ======================================================================
    always_comb begin
        op      = ALU_ADD;
        use_imm = 1'b1;
        imm     = {{(XLEN-12){instr.i.imm12[11]}}, instr.i.imm12}; // I immediate
        wen     = 1'b1;
        illegal = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                case (instr.i.funct3)
                    3'b000: op = ALU_ADD;
                    3'b010: op = ALU_SLT;
                    3'b011: op = ALU_SLTU;
                    3'b100: op = ALU_XOR;
                    3'b110: op = ALU_OR;
                    3'b111: op = ALU_AND;
                    3'b001: begin
                        op      = ALU_SLL;
                        imm     = XLEN'(instr.r.rs2); // shamt
                        illegal = !f7_zero;
                    end
                    default: begin         // 101, srli / srai
                        op      = f7_alt ? ALU_SRA : ALU_SRL;
                        imm     = XLEN'(instr.r.rs2);
                        illegal = !(f7_zero || f7_alt);
                    end
                endcase
            end
            OPC_OP: begin
                use_imm = 1'b0;
                case (instr.r.funct3)
                    3'b000: op = f7_alt ? ALU_SUB : ALU_ADD;
                    3'b001: op = ALU_SLL;
                    3'b010: op = ALU_SLT;
                    3'b011: op = ALU_SLTU;
                    3'b100: op = ALU_XOR;
                    3'b101: op = f7_alt ? ALU_SRA : ALU_SRL;
                    3'b110: op = ALU_OR;
                    default: op = ALU_AND;
                endcase
                // alt funct7 only on add/sub and srl/sra, M extension lands here too
                if (f7_alt) begin
                    illegal = !(instr.r.funct3 == 3'b000 || instr.r.funct3 == 3'b101);
                end else begin
                    illegal = !f7_zero;
                end
            end
            OPC_LUI: begin
                op  = ALU_PASS_B;
                imm = {instr.i.imm12, instr.i.rs1, instr.i.funct3, 12'b0}; // U immediate
            end
            default: begin
                illegal = 1'b1;            // loads, stores, branches, system...
            end
        endcase
        if (illegal) wen = 1'b0;
    end

    // ======================================================================
    // bundle register
    // ======================================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dec_o.valid <= 1'b0;
        end else begin
            dec_o.valid <= instr_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            dec_o.op      <= op;
            dec_o.rs1     <= instr.r.rs1;
            dec_o.rs2     <= instr.r.rs2;
            dec_o.rd      <= instr.r.rd;
            dec_o.imm     <= imm;
            dec_o.use_imm <= use_imm;
            dec_o.wen     <= wen;
            dec_o.illegal <= illegal;
        end
    end

endmodule

//--- design/rv_execute.sv
`timescale 1ns/1ps

module rv_execute import rv_alu_pkg::*; (
    input  logic   clk_i,
    input  logic   arst_n_i,
    dec_exe_if.exe dec_i,
    exe_res_if.exe res_o
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_out;

    // ======================================================================
    // operand fetch
    // ======================================================================
    assign res_o.rs1_idx = dec_i.rs1;
    assign res_o.rs2_idx = dec_i.rs2;

    assign op_a  = res_o.rs1_data;      // bypass handled in result
    assign op_b  = dec_i.use_imm ? dec_i.imm : res_o.rs2_data;
    assign shamt = op_b[4:0];

    // ======================================================================
    // alu
    // ======================================================================
    always_comb begin
        case (dec_i.op)
            ALU_ADD: begin
                alu_out = op_a + op_b;
            end
            ALU_SUB: begin
                alu_out = op_a - op_b;
            end
            ALU_SLL: begin
                alu_out = op_a << shamt;
            end
            ALU_SLT: begin
                alu_out = XLEN'($signed(op_a) < $signed(op_b));
            end
            ALU_SLTU: begin
                alu_out = XLEN'(op_a < op_b);
            end
            ALU_XOR: begin
                alu_out = op_a ^ op_b;
            end
            ALU_SRL: begin
                alu_out = op_a >> shamt;
            end
            ALU_SRA: begin
                alu_out = $unsigned($signed(op_a) >>> shamt); // sign fill
            end
            ALU_OR: begin
                alu_out = op_a | op_b;
            end
            ALU_AND: begin
                alu_out = op_a & op_b;
            end
            default: begin
                alu_out = op_b;            // pass b, lui
            end
        endcase
    end

    // ======================================================================
    // result register
    // ======================================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_o.valid <= 1'b0;
        end else begin
            res_o.valid <= dec_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dec_i.valid) begin
            res_o.rd      <= dec_i.rd;
            res_o.wen     <= dec_i.wen;
            res_o.illegal <= dec_i.illegal;
            res_o.data    <= alu_out;
        end
    end

endmodule

//--- design/rv_result.sv
`timescale 1ns/1ps

module rv_result import rv_alu_pkg::*; #(
    parameter int CNT_W = 16
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    exe_res_if.res           exe_i,
    // host read port
    input  reg_idx_t         reg_idx_i,
    output logic [XLEN-1:0]  reg_data_o,
    output logic [CNT_W-1:0] retired_o,
    output logic [CNT_W-1:0] illegal_o
);

    logic [XLEN-1:0] regs [NREGS];
    logic            do_write;
    logic            fwd_rs1;
    logic            fwd_rs2;

    // never lands in x0
    assign do_write = exe_i.valid & exe_i.wen & ~exe_i.illegal & (exe_i.rd != 5'd0);

    // ======================================================================
    // operand reads with bypass from the pending write
    // ======================================================================
    assign fwd_rs1 = do_write && (exe_i.rd == exe_i.rs1_idx);
    assign fwd_rs2 = do_write && (exe_i.rd == exe_i.rs2_idx);

    assign exe_i.rs1_data = fwd_rs1 ? exe_i.data : regs[exe_i.rs1_idx];
    assign exe_i.rs2_data = fwd_rs2 ? exe_i.data : regs[exe_i.rs2_idx];

    assign reg_data_o = regs[reg_idx_i];

    // ======================================================================
    // register file
    // ======================================================================
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int n = 0; n < NREGS; n++) begin
                regs[n] <= '0;
            end
        end else if (do_write) begin
            regs[exe_i.rd] <= exe_i.data;
        end
    end

    // retired and illegal counts, wrap at CNT_W
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            retired_o <= '0;
            illegal_o <= '0;
        end else if (exe_i.valid) begin
            if (exe_i.illegal) begin
                illegal_o <= illegal_o + 1'b1;
            end else begin
                retired_o <= retired_o + 1'b1; // rd = x0 still retires
            end
        end
    end

endmodule

//--- design/rv_alu_core.sv
`timescale 1ns/1ps

module rv_alu_core import rv_alu_pkg::*; #(
    parameter int CNT_W = 16
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  logic [ADR_W-1:0] wb_adr_i,
    input  logic [XLEN-1:0]  wb_dat_i,
    input  logic [3:0]       wb_sel_i,
    output logic [XLEN-1:0]  wb_dat_o,
    output logic             wb_ack_o
);

    logic [XLEN-1:0]  instr;
    logic             instr_valid;
    reg_idx_t         reg_idx;
    logic [XLEN-1:0]  reg_data;
    logic [CNT_W-1:0] retired;
    logic [CNT_W-1:0] illegal;

    dec_exe_if dec_exe ();
    exe_res_if exe_res ();

    rv_bus_port #(.CNT_W(CNT_W)) u_bus_port (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_sel_i      (wb_sel_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .instr_o       (instr),
        .instr_valid_o (instr_valid),
        .reg_idx_o     (reg_idx),
        .reg_data_i    (reg_data),
        .retired_i     (retired),
        .illegal_i     (illegal)
    );

    rv_decode u_decode (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .dec_o         (dec_exe.dec)
    );

    rv_execute u_execute (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .dec_i    (dec_exe.exe),
        .res_o    (exe_res.exe)
    );

    rv_result #(.CNT_W(CNT_W)) u_result (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .exe_i      (exe_res.res),
        .reg_idx_i  (reg_idx),
        .reg_data_o (reg_data),
        .retired_o  (retired),
        .illegal_o  (illegal)
    );

endmodule

//--- tests/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;   // 50% duty
        end
    end

endmodule

//--- tests/rv_alu_core_tb.sv
`timescale 1ns/1ps

module rv_alu_core_tb import rv_alu_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int N_TRANS    = 480;   // bus transactions over all tests, rounded up
    localparam int TIMEOUT_NS = N_TRANS * 10 * CLK_PERIOD;
    localparam int ACK_LIMIT  = 8;     // cycles to wait for an ack

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [6:0] F7_ALT     = 7'b0100000; // sub / sra
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    logic             clk;
    logic             arst_n;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [ADR_W-1:0] wb_adr;
    logic [31:0]      wb_dat_i;
    logic [3:0]       wb_sel;
    logic [31:0]      wb_dat_o;
    logic             wb_ack;

    // reference model state
    logic [31:0] m_regs [32];
    logic [15:0] m_retired;
    logic [15:0] m_illegal;

    integer seed;
    int     errors;
    int     checks;

    tb_clkgen #(.PERIOD_NS(CLK_PERIOD)) u_clkgen (.clk_o(clk));

    rv_alu_core rv_alu_core_i (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack)
    );

    // ======================================================================
    // instruction words
    // ======================================================================
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};     // op-imm
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // ======================================================================
    // reference model, RV32I rules for the kept subset
    // ======================================================================
    task automatic model_exec(input logic [31:0] ins);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        bad;
        opc = ins[6:0];
        rd  = ins[11:7];
        f3  = ins[14:12];
        f7  = ins[31:25];
        a   = m_regs[ins[19:15]];
        res = '0;
        bad = 1'b0;
        if (opc == 7'b0010011) begin
            b  = {{20{ins[31]}}, ins[31:20]};
            sh = ins[24:20];
        end else begin
            b  = m_regs[ins[24:20]];
            sh = b[4:0];
        end
        if (opc == 7'b0010011 || (opc == 7'b0110011 && (f7 == 7'b0 || f7 == F7_ALT))) begin
            case (f3)
                3'b000: res = (opc == 7'b0110011 && f7 == F7_ALT) ? a - b : a + b;
                3'b001: res = a << sh;
                3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b011: res = (a < b) ? 32'd1 : 32'd0;
                3'b100: res = a ^ b;
                3'b101: res = (f7 == F7_ALT) ? $unsigned($signed(a) >>> sh) : a >> sh;
                3'b110: res = a | b;
                default: res = a & b;
            endcase
            // funct7 matters for every op funct3, but only for shifts in op-imm
            if (f7 == F7_ALT && f3 != 3'b101 && !(opc == 7'b0110011 && f3 == 3'b000)) bad = 1'b1;
            if (opc == 7'b0010011 && f3 == 3'b001 && f7 != 7'b0) bad = 1'b1;
            if (opc == 7'b0010011 && f3 != 3'b001 && f3 != 3'b101) bad = 1'b0;
            if (opc == 7'b0010011 && f3 == 3'b101 && f7 != 7'b0 && f7 != F7_ALT) bad = 1'b1;
        end else if (opc == 7'b0110111) begin
            res = {ins[31:12], 12'h000};           // lui
        end else begin
            bad = 1'b1;
        end
        if (bad) begin
            m_illegal++;
        end else begin
            m_retired++;
            if (rd != 5'd0) m_regs[rd] = res;
        end
    endtask

    // ======================================================================
    // bus access and checks
    // ======================================================================
    task automatic bus_cycle(input logic we, input logic [ADR_W-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_i <= wdata;
        wb_sel   <= 4'hf;
        waited = 0;
        @(posedge clk);
        while (!wb_ack && waited < ACK_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        rdata = wb_dat_o;                          // registered with the ack
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        if (!wb_ack) begin
            errors++;
            $display("no ack from the DUT for the access at address %03h", adr);
        end
    endtask

    task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'h0, data);
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL time=%0t signal=%s expected=%08h actual=%08h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic issue(input logic [31:0] ins);
        wb_write(ADR_STATUS, ins);
        model_exec(ins);
    endtask

    task automatic check_reg(input int n);
        logic [31:0] got;
        wb_read(ADR_REG_BASE + ADR_W'(4 * n), got);
        compare($sformatf("x%0d", n), m_regs[n], got);
    endtask

    task automatic check_status();
        logic [31:0] got;
        wb_read(ADR_STATUS, got);
        compare("status", {m_retired, m_illegal}, got);
    endtask

    task automatic check_regfile();
        for (int n = 0; n < 32; n++) begin
            check_reg(n);
        end
    endtask

    task automatic issue_checked(input logic [31:0] ins, input int rd);
        issue(ins);
        check_reg(rd);
        check_status();
    endtask

    // ======================================================================
    // directed tests
    // ======================================================================
    task automatic after_reset();
        logic [31:0] got;
        check_regfile();
        check_status();
        wb_read(10'h040, got);
        compare("unmapped 040", 32'h0, got);
        wb_read(10'h3fc, got);
        compare("unmapped 3fc", 32'h0, got);
        wb_write(10'h044, i_word(12'd5, 5'd0, 3'b000, 5'd1)); // ignored off the status word
        check_reg(1);
        check_status();
    endtask

    task automatic op_imm_ops();
        issue_checked(i_word(12'hffb, 5'd0, 3'b000, 5'd1), 1);   // addi x1, x0, -5
        issue_checked(i_word(12'h7ff, 5'd1, 3'b000, 5'd2), 2);
        issue_checked(i_word(12'hffc, 5'd1, 3'b010, 5'd3), 3);   // slti, -5 < -4
        issue_checked(i_word(12'hffa, 5'd1, 3'b010, 5'd4), 4);
        issue_checked(i_word(12'hfff, 5'd1, 3'b011, 5'd5), 5);   // sltiu against all ones
        issue_checked(i_word(12'h001, 5'd0, 3'b011, 5'd6), 6);
        issue_checked(i_word(12'hfff, 5'd1, 3'b100, 5'd7), 7);
        issue_checked(i_word(12'h0f0, 5'd1, 3'b110, 5'd8), 8);
        issue_checked(i_word(12'h7f3, 5'd1, 3'b111, 5'd9), 9);
        issue_checked(i_word({7'b0, 5'd31}, 5'd1, 3'b001, 5'd10), 10);
        issue_checked(i_word({7'b0, 5'd4}, 5'd1, 3'b101, 5'd11), 11);
        issue_checked(i_word({F7_ALT, 5'd4}, 5'd1, 3'b101, 5'd12), 12);
        issue_checked(i_word({F7_ALT, 5'd0}, 5'd2, 3'b101, 5'd13), 13);
    endtask

    task automatic reg_reg_ops();
        issue_checked(u_word(20'h80000, 5'd14, OPC_LUI), 14);
        issue_checked(i_word(12'hfff, 5'd0, 3'b000, 5'd15), 15);
        issue_checked(r_word(7'b0, 5'd15, 5'd14, 3'b000, 5'd16, OPC_OP), 16);
        issue_checked(r_word(F7_ALT, 5'd14, 5'd0, 3'b000, 5'd17, OPC_OP), 17);
        issue_checked(r_word(F7_ALT, 5'd15, 5'd16, 3'b000, 5'd18, OPC_OP), 18);
        issue_checked(r_word(7'b0, 5'd2, 5'd15, 3'b001, 5'd19, OPC_OP), 19);
        issue_checked(r_word(7'b0, 5'd16, 5'd14, 3'b010, 5'd20, OPC_OP), 20); // min < max
        issue_checked(r_word(7'b0, 5'd14, 5'd16, 3'b010, 5'd21, OPC_OP), 21);
        issue_checked(r_word(7'b0, 5'd16, 5'd14, 3'b011, 5'd22, OPC_OP), 22);
        issue_checked(r_word(7'b0, 5'd14, 5'd16, 3'b011, 5'd23, OPC_OP), 23);
        issue_checked(r_word(7'b0, 5'd7, 5'd15, 3'b100, 5'd24, OPC_OP), 24);
        issue_checked(r_word(7'b0, 5'd2, 5'd14, 3'b101, 5'd25, OPC_OP), 25);
        issue_checked(r_word(F7_ALT, 5'd2, 5'd14, 3'b101, 5'd26, OPC_OP), 26);
        issue_checked(r_word(7'b0, 5'd8, 5'd14, 3'b110, 5'd27, OPC_OP), 27);
        issue_checked(r_word(7'b0, 5'd9, 5'd15, 3'b111, 5'd28, OPC_OP), 28);
        // dependent chain, no reads in between
        issue(i_word(12'h001, 5'd0, 3'b000, 5'd27));
        issue(r_word(7'b0, 5'd27, 5'd27, 3'b000, 5'd27, OPC_OP));
        issue(r_word(7'b0, 5'd27, 5'd27, 3'b000, 5'd27, OPC_OP));
        issue(r_word(F7_ALT, 5'd1, 5'd27, 3'b000, 5'd28, OPC_OP));
        issue(r_word(7'b0, 5'd27, 5'd28, 3'b001, 5'd28, OPC_OP));
        issue(r_word(F7_ALT, 5'd27, 5'd28, 3'b101, 5'd28, OPC_OP));
        check_reg(27);
        check_reg(28);
    endtask

    task automatic lui_and_x0();
        issue_checked(u_word(20'habcde, 5'd29, OPC_LUI), 29);
        issue_checked(u_word(20'h12345, 5'd0, OPC_LUI), 0);
        issue_checked(i_word(12'h005, 5'd29, 3'b000, 5'd0), 0);
        issue_checked(r_word(7'b0, 5'd29, 5'd29, 3'b000, 5'd0, OPC_OP), 0);
        issue_checked(u_word(20'hfffff, 5'd30, OPC_LUI), 30);
    endtask

    task automatic illegal_words();
        logic [31:0] words [10];
        words[0] = i_word(12'h000, 5'd1, 3'b010, 5'd5) ^ {25'b0, 7'b0010011 ^ OPC_LOAD};
        words[1] = r_word(7'b0, 5'd2, 5'd1, 3'b010, 5'd4, OPC_STORE);
        words[2] = r_word(7'b0, 5'd2, 5'd1, 3'b000, 5'd8, OPC_BRANCH);
        words[3] = u_word(20'h00010, 5'd1, OPC_JAL);
        words[4] = u_word(20'h12345, 5'd5, OPC_AUIPC);
        words[5] = r_word(F7_MULDIV, 5'd2, 5'd1, 3'b000, 5'd5, OPC_OP);   // mul
        words[6] = r_word(7'b1000000, 5'd2, 5'd1, 3'b000, 5'd5, OPC_OP);
        words[7] = r_word(F7_ALT, 5'd2, 5'd1, 3'b001, 5'd5, OPC_OP);
        words[8] = i_word({F7_ALT, 5'd3}, 5'd1, 3'b001, 5'd5);           // slli, alt funct7
        words[9] = r_word(7'b0011000, 5'd2, 5'd0, 3'b000, 5'd0, OPC_SYSTEM); // mret
        for (int k = 0; k < 10; k++) begin
            issue(words[k]);
            check_status();
        end
        check_regfile();
    endtask

    task automatic random_mix();
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] ins;
        logic [6:0]  f7;
        for (int k = 0; k < 200; k++) begin
            ra = $random(seed);
            rb = $random(seed);
            f7 = (rb[7] && (ra[14:12] == 3'b000 || ra[14:12] == 3'b101)) ? F7_ALT : 7'b0;
            case (rb[2:0])
                3'd0, 3'd1: begin
                    if (ra[13:12] == 2'b01) begin
                        ins = i_word({f7, ra[24:20]}, ra[19:15], ra[14:12], ra[11:7]);
                    end else begin
                        ins = i_word(ra[31:20], ra[19:15], ra[14:12], ra[11:7]);
                    end
                end
                3'd2, 3'd3: ins = r_word(f7, ra[24:20], ra[19:15], ra[14:12], ra[11:7], OPC_OP);
                3'd4: ins = u_word(ra[31:12], ra[11:7], OPC_LUI);
                3'd5: ins = r_word(F7_MULDIV, ra[24:20], ra[19:15], ra[14:12], ra[11:7], OPC_OP);
                3'd6: begin
                    case (rb[6:4])
                        3'd0: ins = {ra[31:7], OPC_LOAD};
                        3'd1: ins = {ra[31:7], OPC_STORE};
                        3'd2: ins = {ra[31:7], OPC_BRANCH};
                        3'd3: ins = {ra[31:7], OPC_JAL};
                        3'd4: ins = {ra[31:7], OPC_AUIPC};
                        default: ins = {ra[31:7], OPC_SYSTEM};
                    endcase
                end
                default: ins = ra;                 // raw word, any decode
            endcase
            issue(ins);
        end
        check_regfile();
        check_status();
    endtask

    // ======================================================================
    // run and report
    // ======================================================================
    initial begin
        wb_cyc    <= 1'b0;
        wb_stb    <= 1'b0;
        wb_we     <= 1'b0;
        wb_adr    <= '0;
        wb_dat_i  <= '0;
        wb_sel    <= 4'h0;
        arst_n    <= 1'b0;
        seed      = 32'h69d4_e6d6;
        errors    = 0;
        checks    = 0;
        m_retired = '0;
        m_illegal = '0;
        for (int n = 0; n < 32; n++) begin
            m_regs[n] = '0;
        end
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        after_reset();
        op_imm_ops();
        reg_reg_ops();
        lui_and_x0();
        illegal_words();
        random_mix();
        $display("errors: %0d of %0d checks, model retired %0d illegal %0d",
                 errors, checks, m_retired, m_illegal);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- rv_alu_core.f
design/rv_alu_pkg.sv
design/dec_exe_if.sv
design/exe_res_if.sv
design/rv_bus_port.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_alu_core.sv
tests/tb_clkgen.sv
tests/rv_alu_core_tb.sv

//--- Makefile
# Verilator simulation of rv_alu_core
# every variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= rv_alu_core_tb
FILELIST  ?= rv_alu_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
